//--- source/pixel_format_pkg.sv
// Pixel formats
// Sample, colour and stored-word types
`default_nettype none

package pixel_format_pkg;

  // Sensor sample width
  parameter int raw_width = 12;

  typedef logic [raw_width-1:0] raw_pixel_t;  // One Bayer sample
  typedef logic [7:0]           colour8_t;    // 8-bit colour or hue
  typedef logic [11:0]          coord_t;      // Column or row count
  typedef logic [15:0]          pixel_word_t; // Frame store word

  // Output mux opcode
  typedef enum logic {
    mode_rgb555 = 1'b0,  // 0 + 5:5:5 colour
    mode_hue    = 1'b1   // 8 zero bits + hue
  } output_mode_t;

endpackage

`default_nettype wire

//--- source/capture_ctrl_pkg.sv
// Capture control types
`default_nettype none

package capture_ctrl_pkg;

  // Capture FSM states
  typedef enum logic [1:0] {
    cap_idle       = 2'd0,  // Waiting for start
    cap_wait_frame = 2'd1,  // Armed, waiting for frame valid rise
    cap_active     = 2'd2   // Frame being captured
  } capture_state_t;

  // Frame counter, also used for the rate meter
  typedef logic [31:0] frame_count_t;

endpackage

`default_nettype wire

//--- source/frame_capture_control.sv
// Sensor capture control
`default_nettype none
`timescale 1ns/1ps

module frame_capture_control
  import pixel_format_pkg::*;
  import capture_ctrl_pkg::*;
(
  input  logic         ccd_pixel_clk,
  input  logic         video_stream_reset_n,
  input  raw_pixel_t   ccd_data,
  input  logic         ccd_frame_valid,
  input  logic         ccd_line_valid,
  input  logic         capture_start,   // Frames taken while high
  output raw_pixel_t   pix_data,
  output logic         pix_valid,
  output coord_t       pix_x,
  output coord_t       pix_y,
  output frame_count_t frame_count
);

  raw_pixel_t     data_r;           // Registered sensor sample
  logic           fv_r, lv_r;       // Registered valids
  logic           fv_d, lv_d;       // One cycle older for edge detect
  capture_state_t state;
  logic           fv_rise, fv_fall, lv_fall;
  logic           take_pixel;

  assign fv_rise = fv_r & ~fv_d;
  assign fv_fall = ~fv_r & fv_d;
  assign lv_fall = ~lv_r & lv_d;

  // Pixels only pass inside an active frame
  assign take_pixel = fv_r && lv_r && (state == cap_active);

  // ========================================
  // Input registers
  // ========================================
  always_ff @(posedge ccd_pixel_clk) begin
    data_r <= ccd_data;
    if (!video_stream_reset_n) begin
      fv_r <= 1'b0;
      lv_r <= 1'b0;
      fv_d <= 1'b0;
      lv_d <= 1'b0;
    end else begin
      fv_r <= ccd_frame_valid;
      lv_r <= ccd_line_valid;
      fv_d <= fv_r;
      lv_d <= lv_r;
    end
  end

  // ========================================
  // Capture FSM
  // ========================================
  always_ff @(posedge ccd_pixel_clk) begin
    if (!video_stream_reset_n) begin
      state <= cap_idle;
    end else begin
      case (state)
        cap_idle: begin
          if (capture_start) state <= cap_wait_frame;  // Arm
        end
        cap_wait_frame: begin
          if (!capture_start) state <= cap_idle;       // Start dropped first
          else if (fv_rise) state <= cap_active;
        end
        cap_active: begin
          // Whole frame always finishes
          if (fv_fall) state <= capture_start ? cap_wait_frame : cap_idle;
        end
        default: state <= cap_idle;
      endcase
    end
  end

  // Pixel payload
  always_ff @(posedge ccd_pixel_clk) begin
    if (take_pixel) pix_data <= data_r;
  end

  // Valid strobe, coordinates and frame counter
  always_ff @(posedge ccd_pixel_clk) begin
    if (!video_stream_reset_n) begin
      pix_valid   <= 1'b0;
      pix_x       <= '0;
      pix_y       <= '0;
      frame_count <= '0;
    end else begin
      pix_valid <= take_pixel;
      if (lv_fall) begin
        pix_x <= '0;            // End of line
        pix_y <= pix_y + 1'b1;
      end else if (pix_valid) begin
        pix_x <= pix_x + 1'b1;  // Next column
      end
      if (fv_rise) pix_y <= '0;  // Row 0 of a new frame
      if (state == cap_active && fv_fall) frame_count <= frame_count + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- source/frame_rate_timer.sv
// Frame rate meter
`default_nettype none
`timescale 1ns/1ps

module frame_rate_timer
  import capture_ctrl_pkg::*;
#(
  parameter int ticks_per_window = 96000000  // Window length in pixel clocks
) (
  input  logic         ccd_pixel_clk,
  input  logic         video_stream_reset_n,
  input  frame_count_t frame_count,
  output frame_count_t frame_rate,   // Frames in the last window
  output logic         rate_pulse    // Toggles at each window end
);

  localparam int tick_width = (ticks_per_window > 1) ? $clog2(ticks_per_window) : 1;
  localparam logic [tick_width-1:0] last_tick = tick_width'(ticks_per_window - 1);

  logic [tick_width-1:0] tick_count;
  frame_count_t          frame_snap;  // Count at previous window end

  always_ff @(posedge ccd_pixel_clk) begin
    if (!video_stream_reset_n) begin
      tick_count <= '0;
      frame_snap <= '0;
      frame_rate <= '0;
      rate_pulse <= 1'b0;
    end else if (tick_count == last_tick) begin
      tick_count <= '0;                        // Window end
      rate_pulse <= ~rate_pulse;
      frame_rate <= frame_count - frame_snap;  // Frames seen this window
      frame_snap <= frame_count;
    end else begin
      tick_count <= tick_count + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- source/bayer_to_rgb.sv
// Bayer to RGB conversion
// One line buffer, one RGB pixel per 2x2 cell
`default_nettype none
`timescale 1ns/1ps

module bayer_to_rgb
  import pixel_format_pkg::*;
#(
  parameter int line_width_max = 1280  // Line buffer depth
) (
  input  logic       ccd_pixel_clk,
  input  logic       video_stream_reset_n,
  input  raw_pixel_t pix_data,
  input  logic       pix_valid,
  input  coord_t     pix_x,
  input  coord_t     pix_y,
  output raw_pixel_t red,
  output raw_pixel_t green,
  output raw_pixel_t blue,
  output logic       rgb_valid
);

  // Pattern
  //   even rows: G R G R ...
  //   odd rows:  B G B G ...

  localparam int addr_width = (line_width_max > 1) ? $clog2(line_width_max) : 1;

  raw_pixel_t line_buf [line_width_max];  // Even row samples by column
  raw_pixel_t odd_prev;                   // Last odd-row sample (B at even x)

  logic [addr_width-1:0] col_addr;
  logic [addr_width-1:0] col_addr_m1;
  logic                  even_row;
  logic                  cell_done;     // Odd row, odd column
  logic [raw_width:0]    green_sum;     // One extra bit for the carry

  assign col_addr    = pix_x[addr_width-1:0];
  assign col_addr_m1 = col_addr - 1'b1;
  assign even_row    = ~pix_y[0];
  assign cell_done   = pix_valid & pix_y[0] & pix_x[0];

  // Upper G (buffer) plus lower G (current)
  assign green_sum = {1'b0, line_buf[col_addr_m1]} + {1'b0, pix_data};

  // ========================================
  // Line buffer and held sample
  // ========================================
  always_ff @(posedge ccd_pixel_clk) begin
    if (pix_valid && even_row) line_buf[col_addr] <= pix_data;
    if (pix_valid && !even_row) odd_prev <= pix_data;  // Blue for the next cell
  end

  // ========================================
  // RGB output
  // ========================================
  always_ff @(posedge ccd_pixel_clk) begin
    if (cell_done) begin
      red   <= line_buf[col_addr];          // R above current G
      green <= green_sum[raw_width:1];      // Average of both greens
      blue  <= odd_prev;                    // B left of current G
    end
  end

  always_ff @(posedge ccd_pixel_clk) begin
    if (!video_stream_reset_n) rgb_valid <= 1'b0;
    else rgb_valid <= cell_done;  // One strobe per cell
  end

endmodule

`default_nettype wire

//--- source/rgb_to_hue.sv
// RGB to hue, two stages
`default_nettype none
`timescale 1ns/1ps

module rgb_to_hue
  import pixel_format_pkg::*;
(
  input  logic       ccd_pixel_clk,
  input  logic       video_stream_reset_n,
  input  raw_pixel_t red,
  input  raw_pixel_t green,
  input  raw_pixel_t blue,
  input  logic       rgb_valid,
  output colour8_t   hue,
  output logic       hue_valid
);

  // Which channel is largest
  localparam logic [1:0] sel_red   = 2'd0;
  localparam logic [1:0] sel_green = 2'd1;
  localparam logic [1:0] sel_blue  = 2'd2;

  colour8_t r8, g8, b8;        // Top bits only
  colour8_t max_c, min_c;
  logic [1:0] max_sel_c;

  // Stage 1 registers
  colour8_t          max_q, min_q, delta_q;
  logic [1:0]        max_sel_q;
  logic signed [8:0] num_q;    // Colour difference for the hue sector
  logic              valid_q;

  // Stage 2 arithmetic
  logic signed [15:0] num_ext, scaled, divisor, quotient;
  colour8_t           offset;

  assign r8 = red[raw_width-1 -: 8];
  assign g8 = green[raw_width-1 -: 8];
  assign b8 = blue[raw_width-1 -: 8];

  // ========================================
  // Stage 1, max / min / delta
  // ========================================
  always_comb begin
    if (r8 >= g8 && r8 >= b8) max_sel_c = sel_red;  // Ties favour red
    else if (g8 >= b8) max_sel_c = sel_green;       // then green
    else max_sel_c = sel_blue;
    max_c = (max_sel_c == sel_red) ? r8 : (max_sel_c == sel_green) ? g8 : b8;
    min_c = (r8 <= g8 && r8 <= b8) ? r8 : (g8 <= b8) ? g8 : b8;
  end

  always_ff @(posedge ccd_pixel_clk) begin
    max_q     <= max_c;
    min_q     <= min_c;
    delta_q   <= max_c - min_c;
    max_sel_q <= max_sel_c;
    case (max_sel_c)
      sel_red:   num_q <= $signed({1'b0, g8}) - $signed({1'b0, b8});
      sel_green: num_q <= $signed({1'b0, b8}) - $signed({1'b0, r8});
      default:   num_q <= $signed({1'b0, r8}) - $signed({1'b0, g8});
    endcase
  end

  // ========================================
  // Stage 2, sector offset plus 43*num/delta
  // ========================================
  always_comb begin
    num_ext  = num_q;                          // Sign extend
    scaled   = num_ext * 16'sd43;
    divisor  = (delta_q == 8'd0) ? 16'sd1 : $signed({8'd0, delta_q});  // No div by 0
    quotient = scaled / divisor;               // Truncates toward zero
    case (max_sel_q)
      sel_red:   offset = 8'd0;
      sel_green: offset = 8'd85;
      default:   offset = 8'd171;
    endcase
  end

  always_ff @(posedge ccd_pixel_clk) begin
    if (max_q == min_q) hue <= 8'd0;            // Grey, no hue
    else hue <= offset + quotient[7:0];         // Wraps modulo 256
  end

  always_ff @(posedge ccd_pixel_clk) begin
    if (!video_stream_reset_n) begin
      valid_q   <= 1'b0;
      hue_valid <= 1'b0;
    end else begin
      valid_q   <= rgb_valid;
      hue_valid <= valid_q;
    end
  end

endmodule

`default_nettype wire

//--- source/pixel_output_mux.sv
// Frame store word select
`default_nettype none
`timescale 1ns/1ps

module pixel_output_mux
  import pixel_format_pkg::*;
(
  input  logic         ccd_pixel_clk,
  input  logic         video_stream_reset_n,
  input  output_mode_t output_mode,
  input  logic [2:0]   channel_enable,  // {red, green, blue}
  input  raw_pixel_t   red,
  input  raw_pixel_t   green,
  input  raw_pixel_t   blue,
  input  logic         rgb_valid,
  input  colour8_t     hue,
  input  logic         hue_valid,
  output pixel_word_t  pixel_word,
  output logic         pixel_write
);

  logic [4:0] red5, green5, blue5;

  // Top 5 bits, masked per channel
  assign red5   = red[raw_width-1 -: 5] & {5{channel_enable[2]}};
  assign green5 = green[raw_width-1 -: 5] & {5{channel_enable[1]}};
  assign blue5  = blue[raw_width-1 -: 5] & {5{channel_enable[0]}};

  always_ff @(posedge ccd_pixel_clk) begin
    case (output_mode)
      mode_rgb555: pixel_word <= {1'b0, red5, green5, blue5};
      default:     pixel_word <= {8'h00, hue};
    endcase
  end

  // Write strobe follows the valid of the selected path
  always_ff @(posedge ccd_pixel_clk) begin
    if (!video_stream_reset_n) pixel_write <= 1'b0;
    else pixel_write <= (output_mode == mode_rgb555) ? rgb_valid : hue_valid;
  end

endmodule

`default_nettype wire

//--- source/video_stream_top.sv
// Pixel clock video path
`default_nettype none
`timescale 1ns/1ps

module video_stream_top
  import pixel_format_pkg::*;
  import capture_ctrl_pkg::*;
#(
  parameter int line_width_max   = 1280,
  parameter int ticks_per_window = 96000000
) (
  input  logic         ccd_pixel_clk,
  input  logic         video_stream_reset_n,
  input  raw_pixel_t   ccd_data,
  input  logic         ccd_frame_valid,
  input  logic         ccd_line_valid,
  input  logic         capture_start,
  input  output_mode_t output_mode,
  input  logic [2:0]   channel_enable,
  output pixel_word_t  pixel_word,
  output logic         pixel_write,
  output frame_count_t frame_count,
  output frame_count_t frame_rate,
  output logic         rate_pulse
);

  // Capture to Bayer
  raw_pixel_t pix_data;
  logic       pix_valid;
  coord_t     pix_x, pix_y;
  // Bayer to hue and mux
  raw_pixel_t red, green, blue;
  logic       rgb_valid;
  colour8_t   hue;
  logic       hue_valid;

  frame_capture_control u_capture (
    .ccd_pixel_clk, .video_stream_reset_n,
    .ccd_data, .ccd_frame_valid, .ccd_line_valid, .capture_start,
    .pix_data, .pix_valid, .pix_x, .pix_y, .frame_count
  );

  frame_rate_timer #(.ticks_per_window(ticks_per_window)) u_rate (
    .ccd_pixel_clk, .video_stream_reset_n,
    .frame_count, .frame_rate, .rate_pulse
  );

  bayer_to_rgb #(.line_width_max(line_width_max)) u_bayer (
    .ccd_pixel_clk, .video_stream_reset_n,
    .pix_data, .pix_valid, .pix_x, .pix_y,
    .red, .green, .blue, .rgb_valid
  );

  rgb_to_hue u_hue (
    .ccd_pixel_clk, .video_stream_reset_n,
    .red, .green, .blue, .rgb_valid, .hue, .hue_valid
  );

  pixel_output_mux u_mux (
    .ccd_pixel_clk, .video_stream_reset_n,
    .output_mode, .channel_enable,
    .red, .green, .blue, .rgb_valid, .hue, .hue_valid,
    .pixel_word, .pixel_write
  );

endmodule

`default_nettype wire

//--- verif/video_stream_tb.sv
// Video stream testbench
`default_nettype none
`timescale 1ns/1ps

module video_stream_tb
  import pixel_format_pkg::*;
  import capture_ctrl_pkg::*;
();

  localparam int cols = 8;   // Frame width in samples
  localparam int rows = 6;

  logic         ccd_pixel_clk = 1'b0;
  logic         video_stream_reset_n;
  raw_pixel_t   ccd_data;
  logic         ccd_frame_valid, ccd_line_valid, capture_start;
  output_mode_t output_mode;
  logic [2:0]   channel_enable;
  pixel_word_t  pixel_word;
  logic         pixel_write;
  frame_count_t frame_count, frame_rate;
  logic         rate_pulse;

  logic [31:0]  lfsr = 32'd92203;
  raw_pixel_t   frame_raw [rows][cols];  // Samples of the frame being driven
  pixel_word_t  exp_q [$];               // Expected words, in write order
  pixel_word_t  exp_word;
  frame_count_t exp_frames = '0;
  frame_count_t fc_last = '0;            // frame_count one cycle back
  frame_count_t rate_snap = '0;          // frame_count at previous toggle
  logic         pulse_last = 1'b0;
  int toggles = 0, words_seen = 0, words_due = 0;
  int word_errors = 0, value_errors = 0, rate_errors = 0, timeouts = 0;

  always #50 ccd_pixel_clk = ~ccd_pixel_clk;  // 100 ns period

  video_stream_top #(.line_width_max(16), .ticks_per_window(3000)) dut (
    .ccd_pixel_clk, .video_stream_reset_n, .ccd_data, .ccd_frame_valid,
    .ccd_line_valid, .capture_start, .output_mode, .channel_enable,
    .pixel_word, .pixel_write, .frame_count, .frame_rate, .rate_pulse
  );

  // ========================================
  // Stimulus source and reference model
  // ========================================
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);  // x^32+x^22+x^2+x+1
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};  // One step per bit
      lfsr = lfsr_next(lfsr);
    end
  endtask

  function automatic colour8_t hue_ref(input int r, input int g, input int b);
    int mx, mn, h;
    mx = (r > g) ? r : g;
    mx = (b > mx) ? b : mx;
    mn = (r < g) ? r : g;
    mn = (b < mn) ? b : mn;
    if (mx == mn) return 8'd0;                   // Grey
    if (r == mx) h = 43 * (g - b) / (mx - mn);   // Ties to red first
    else if (g == mx) h = 85 + 43 * (b - r) / (mx - mn);
    else h = 171 + 43 * (r - g) / (mx - mn);
    return 8'(h);                                // Modulo 256
  endfunction

  // Word for the cell closed by odd row y, odd column x
  function automatic pixel_word_t word_ref(input int y, input int x);
    raw_pixel_t  r, g, b;
    logic [12:0] gsum;
    r    = frame_raw[y-1][x];
    gsum = {1'b0, frame_raw[y-1][x-1]} + {1'b0, frame_raw[y][x]};
    g    = gsum[12:1];                           // Mean of both greens
    b    = frame_raw[y][x-1];
    if (output_mode == mode_hue) return {8'h00, hue_ref(r[11:4], g[11:4], b[11:4])};
    return {1'b0, r[11:7] & {5{channel_enable[2]}}, g[11:7] & {5{channel_enable[1]}},
            b[11:7] & {5{channel_enable[0]}}};
  endfunction

  // One 8x6 frame, start optionally changed at the top of row flip_row
  task automatic drive_frame(input int flip_row, input logic flip_val);
    logic        captured;
    logic [31:0] v;
    int          x, y;
    @(negedge ccd_pixel_clk);
    captured        = capture_start;  // Armed before the frame began
    ccd_frame_valid = 1'b1;
    repeat (2) @(negedge ccd_pixel_clk);
    for (y = 0; y < rows; y++) begin
      if (y == flip_row) capture_start = flip_val;
      for (x = 0; x < cols; x++) begin
        take_bits(12, v);
        ccd_data        = v[11:0];
        ccd_line_valid  = 1'b1;
        frame_raw[y][x] = v[11:0];
        if (captured && y[0] && x[0]) begin
          exp_q.push_back(word_ref(y, x));
          words_due++;
        end
        @(negedge ccd_pixel_clk);
      end
      ccd_line_valid = 1'b0;
      repeat (3) @(negedge ccd_pixel_clk);  // Line gap
    end
    ccd_frame_valid = 1'b0;
    if (captured) exp_frames++;
    repeat (10) @(negedge ccd_pixel_clk);   // Frame gap
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got == exp) else begin
      value_errors++;
      $display("FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  // Drain the expected words, then check count and frame total
  task automatic check_frame_end();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 40) begin
      @(negedge ccd_pixel_clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      timeouts++;
      $display("Timed out with %0d expected words never written", exp_q.size());
      exp_q.delete();
    end
    check_value("words_written", words_seen, words_due);
    check_value("frame_count", frame_count, exp_frames);
  endtask

  // ========================================
  // Output monitors, sampled mid-cycle
  // ========================================
  always @(negedge ccd_pixel_clk) begin
    if (video_stream_reset_n && pixel_write) begin
      words_seen++;
      assert (exp_q.size() != 0) else begin
        word_errors++;
        $display("A word was written while none was due (word %h)", pixel_word);
      end
      if (exp_q.size() != 0) begin
        exp_word = exp_q.pop_front();
        assert (pixel_word == exp_word) else begin
          word_errors++;
          $display("FAILED pixel_word: got %h expected %h", pixel_word, exp_word);
        end
      end
    end
    if (video_stream_reset_n && rate_pulse !== pulse_last) begin
      toggles++;  // Window end, count from the cycle before
      assert (frame_rate == fc_last - rate_snap) else begin
        rate_errors++;
        $display("FAILED frame_rate: got %h expected %h", frame_rate, fc_last - rate_snap);
      end
      rate_snap = fc_last;
    end
    pulse_last = rate_pulse;
    fc_last    = frame_count;
  end

  // ========================================
  // Test sequence
  // ========================================
  initial begin
    int n;
    video_stream_reset_n = 1'b0;
    ccd_data             = '0;
    ccd_frame_valid      = 1'b0;
    ccd_line_valid       = 1'b0;
    capture_start        = 1'b0;
    output_mode          = mode_rgb555;
    channel_enable       = 3'b111;
    repeat (5) @(negedge ccd_pixel_clk);
    video_stream_reset_n = 1'b1;
    @(negedge ccd_pixel_clk);
    check_value("pixel_write", pixel_write, 0);
    check_value("frame_count", frame_count, 0);
    check_value("frame_rate", frame_rate, 0);
    check_value("rate_pulse", rate_pulse, 0);

    drive_frame(-1, 1'b0);  // Start low, nothing captured
    check_frame_end();
    drive_frame(2, 1'b1);   // Start mid-frame, frame skipped
    check_frame_end();
    drive_frame(-1, 1'b0);  // First full capture
    check_frame_end();
    channel_enable = 3'b010;  // Green only
    drive_frame(-1, 1'b0);
    check_frame_end();

    output_mode    = mode_hue;
    channel_enable = 3'b111;
    repeat (2) begin
      drive_frame(-1, 1'b0);
      check_frame_end();
    end

    output_mode = mode_rgb555;
    drive_frame(3, 1'b0);   // Start drops mid-frame, frame completes
    check_frame_end();
    repeat (2) begin
      drive_frame(-1, 1'b0);  // No more words
      check_frame_end();
    end

    // Keep capturing until several rate windows have closed
    capture_start = 1'b1;
    n = 0;
    while (toggles < 3 && n < 200) begin
      drive_frame(-1, 1'b0);
      check_frame_end();
      n++;
    end
    if (toggles < 3) begin
      timeouts++;
      $display("Timed out waiting for rate_pulse toggles, saw %0d", toggles);
    end

    $display("Errors: words %0d, values %0d, rate %0d, timeouts %0d",
             word_errors, value_errors, rate_errors, timeouts);
    if (word_errors + value_errors + rate_errors + timeouts == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
source/pixel_format_pkg.sv
source/capture_ctrl_pkg.sv
source/frame_capture_control.sv
source/frame_rate_timer.sv
source/bayer_to_rgb.sv
source/rgb_to_hue.sv
source/pixel_output_mux.sv
source/video_stream_top.sv
verif/video_stream_tb.sv
